/* Makefile */
# Verilator flow for the stack push/pull engine

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_stk_top
RTL_TOP    ?= stk_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
LINT_FLAGS ?=
SIM_FLAGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_stk_mem.sv */
/* testbench byte memory
   64 KiB behind the stack engine, combinational read and clocked write */
`timescale 1ns/1ps

module tb_stk_mem (
    input  logic        clk,
    input  logic [15:0] addr,
    input  logic [7:0]  wdata,
    input  logic        we,
    output logic [7:0]  rdata
);

    logic [7:0] mem [0:65535];

    // fill from every address bit so misplaced reads show up
    initial begin
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a = 16'(i);
            mem[a] = a[15:8] ^ {a[6:0], a[7]} ^ 8'h3C;
        end
    end

    assign rdata = mem[addr];   // din of the engine

    // a stalled push writes the same byte again
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

/* bench/tb_stk_top.sv */
/* stack engine testbench
   table driven push/pull requests checked against a byte level stack model */
`timescale 1ns/1ps
`include "stk_macros.svh"

module tb_stk_top;
    import stk_pkg::*;

    localparam int NROWS = 16;
    localparam int LIMIT = 40 * NROWS + 100;   // cycle budget of the whole run

    typedef struct {
        int         pre;            // preload 0 none, 1 random, 2 zero
        logic [7:0] pre_cc;
        int         form;           // 0 plain, 1 push all, 2 rti cc, 3 rti rest
        logic [7:0] op;
        logic [7:0] pd;
        bit         gaps;           // random cen while busy
        bit         poke;           // go strobes and loads while busy
        int         len;            // busy length in enabled cycles
        int         s_delta;
        int         u_delta;
    } row_t;

    row_t rows [NROWS] = '{
        '{1, 8'h80, 0, `STK_OP_PSHS, 8'hFF, 0, 0, 12, -12, 0},   // whole set onto S
        '{2, 8'h00, 0, `STK_OP_PULS, 8'hFF, 0, 0, 12, 12, 0},
        '{1, 8'h00, 0, `STK_OP_PSHU, 8'h56, 1, 0, 6, 0, -6},     // S, X, B, A onto U
        '{2, 8'h00, 0, `STK_OP_PULU, 8'h56, 0, 0, 6, 0, 6},
        '{1, 8'h00, 0, `STK_OP_PSHS, 8'h40, 0, 0, 2, -2, 0},     // U onto S
        '{0, 8'h00, 0, `STK_OP_PSHU, 8'h01, 0, 0, 1, 0, -1},     // move U away
        '{0, 8'h00, 0, `STK_OP_PULS, 8'h40, 1, 0, 2, 2, 1},      // U comes back
        '{1, 8'h00, 1, `STK_OP_PSHS, 8'h00, 0, 0, 3, -3, 0},     // short frame
        '{2, 8'h00, 2, `STK_OP_PULS, 8'h00, 0, 0, 1, 1, 0},
        '{0, 8'h00, 3, `STK_OP_PULS, 8'h00, 0, 0, 2, 2, 0},
        '{1, 8'h80, 1, `STK_OP_PSHS, 8'h00, 1, 0, 12, -12, 0},   // full frame
        '{2, 8'h00, 2, `STK_OP_PULS, 8'h00, 0, 0, 1, 1, 0},
        '{0, 8'h00, 3, `STK_OP_PULS, 8'h00, 1, 0, 11, 11, 0},
        '{1, 8'h00, 0, `STK_OP_PSHS, 8'h00, 0, 0, 0, 0, 0},      // empty mask
        '{1, 8'h00, 0, `STK_OP_PSHU, 8'hFF, 1, 1, 12, 0, -12},
        '{2, 8'h00, 0, `STK_OP_PULU, 8'hFF, 0, 1, 12, 0, 12}
    };

    logic clk, rst, cen;
    logic [7:0] op, postdata, din, dout;
    logic psh_go, pul_go, psh_all, rti_cc, rti_other, ld_en, we, busy;
    stk_reg_e ld_sel;
    logic [15:0] ld_data, addr;
    logic [7:0] reg_cc, reg_a, reg_b, reg_dp;
    logic [15:0] reg_x, reg_y, reg_pc, reg_s, reg_u;

    logic [15:0] m_reg [0:7];       // model registers by index with the US slot left unused
    logic [15:0] m_s, m_u;
    logic [7:0]  model_mem [0:65535];
    logic [15:0] touched [$];       // addresses written by the last push
    int          errors = 0;
    int          checks = 0;
    int          busy_cycles = 0;
    int          cycles = 0;

    stk_top UUT (
        .clk(clk), .rst(rst), .cen(cen), .op(op), .postdata(postdata),
        .psh_go(psh_go), .pul_go(pul_go), .psh_all(psh_all), .rti_cc(rti_cc),
        .rti_other(rti_other), .ld_en(ld_en), .ld_sel(ld_sel), .ld_data(ld_data),
        .din(din), .addr(addr), .dout(dout), .we(we), .busy(busy),
        .reg_cc(reg_cc), .reg_a(reg_a), .reg_b(reg_b), .reg_dp(reg_dp),
        .reg_x(reg_x), .reg_y(reg_y), .reg_pc(reg_pc), .reg_s(reg_s), .reg_u(reg_u)
    );

    tb_stk_mem mem_i (.clk(clk), .addr(addr), .wdata(dout), .we(we), .rdata(din));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (busy && cen) busy_cycles++;    // one byte per enabled busy cycle
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input stk_postbyte_u got,
                              input stk_postbyte_u exp);
        checks++;
        if (got.raw !== exp.raw) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got.raw, exp.raw);
        end
    endtask

    // registers and both stack pointers against the model
    task automatic compare_state();
        check_word("reg_s", reg_s, m_s);
        check_word("reg_u", reg_u, m_u);
        check_byte("reg_cc", reg_cc, m_reg[REG_CC][7:0]);
        check_byte("reg_a", reg_a, m_reg[REG_A][7:0]);
        check_byte("reg_b", reg_b, m_reg[REG_B][7:0]);
        check_byte("reg_dp", reg_dp, m_reg[REG_DP][7:0]);
        check_word("reg_x", reg_x, m_reg[REG_X]);
        check_word("reg_y", reg_y, m_reg[REG_Y]);
        check_word("reg_pc", reg_pc, m_reg[REG_PC]);
    endtask

    task automatic load_reg(input stk_reg_e sel, input logic [15:0] v);
        ld_en = 1'b1;
        ld_sel = sel;
        ld_data = v;
        m_reg[sel] = v;
        @(posedge clk);
        #2;
        ld_en = 1'b0;
    endtask

    task automatic preload_all(input logic rnd, input logic [7:0] cc_val);
        logic [15:0] v;
        load_reg(REG_CC, {8'h00, cc_val});
        for (int i = 1; i < 8; i++) begin
            if (i != int'(REG_US)) begin
                v = rnd ? 16'($urandom) : 16'h0000;
                if (i < int'(REG_X)) v[15:8] = 8'h00;   // byte registers
                load_reg(stk_reg_e'(3'(i)), v);
            end
        end
    endtask

    // starting mask from the interrupt forms or the postbyte
    function automatic stk_postbyte_u start_mask(input row_t r);
        stk_postbyte_u m;
        logic          e;
        e = m_reg[REG_CC][`STK_CC_E];
        case (r.form)
            1: m.raw = e ? 8'hFF : 8'h81;
            2: m.raw = 8'h01;
            3: m.raw = e ? 8'hFE : 8'h80;
            default: m.raw = r.pd;
        endcase
        return m;
    endfunction

    // push PC first with predecrement, pull CC first with postincrement
    task automatic model_move(input stk_postbyte_u m, input logic pull, input logic use_u);
        logic [15:0] sp;
        logic [15:0] v;
        logic [2:0]  k;
        sp = use_u ? m_u : m_s;
        for (int i = 0; i < 8; i++) begin
            k = pull ? 3'(i) : 3'(7 - i);
            if (m.raw[k]) begin
                v = (k == REG_US) ? (use_u ? m_s : m_u) : m_reg[k];
                if (pull && k >= REG_X) begin
                    v[15:8] = model_mem[sp];     // high byte at the lower address
                    v[7:0] = model_mem[sp + 16'd1];
                    sp = sp + 16'd2;
                end else if (pull) begin
                    v = {8'h00, model_mem[sp]};
                    sp = sp + 16'd1;
                end else begin
                    sp = sp - 16'd1;
                    model_mem[sp] = v[7:0];
                    touched.push_back(sp);
                    if (k >= REG_X) begin
                        sp = sp - 16'd1;
                        model_mem[sp] = v[15:8];
                        touched.push_back(sp);
                    end
                end
                if (pull && k == REG_US) begin
                    if (use_u) m_s = v;
                    else m_u = v;
                end else if (pull) begin
                    m_reg[k] = v;
                end
            end
        end
        if (use_u) m_u = sp;
        else m_s = sp;
    endtask

    task automatic run_row(input row_t r);
        stk_postbyte_u exp_mask;
        logic          pull;
        logic [15:0]   s_before, u_before, a;
        pull = r.form >= 2 || r.op == `STK_OP_PULS || r.op == `STK_OP_PULU;
        if (r.pre != 0) preload_all(r.pre == 1, r.pre_cc);
        exp_mask = start_mask(r);
        model_move(exp_mask, pull, r.form == 0 && r.op[0]);
        s_before = reg_s;
        u_before = reg_u;
        busy_cycles = 0;
        op = r.op;
        postdata = r.pd;
        psh_all = r.form == 1;
        rti_cc = r.form == 2;
        rti_other = r.form == 3;
        psh_go = !pull;
        pul_go = pull;
        @(posedge clk);
        #2;
        {psh_go, pul_go, psh_all, rti_cc, rti_other} = 5'b00000;
        check_mask("psh_sel", UUT.psh_sel, exp_mask);
        while (busy) begin
            check_byte("we", {7'd0, we}, {7'd0, !pull});   // writes only on a push
            cen = r.gaps ? ($urandom % 4 != 0) : 1'b1;
            if (r.poke) begin                 // all of this must be ignored
                psh_go = 1'($urandom);
                pul_go = 1'($urandom);
                postdata = 8'($urandom);
                ld_en = 1'b1;
                ld_sel = stk_reg_e'(3'($urandom));
                ld_data = 16'($urandom);
            end
            @(posedge clk);
            #2;
        end
        {cen, ld_en, psh_go, pul_go} = 4'b1000;
        repeat (2) @(posedge clk);
        #2;
        check_byte("busy", {7'd0, busy}, 8'h00);     // stays idle once done
        check_byte("we", {7'd0, we}, 8'h00);
        check_word("busy_cycles", 16'(busy_cycles), 16'(r.len));
        check_word("s_delta", reg_s - s_before, 16'(r.s_delta));
        check_word("u_delta", reg_u - u_before, 16'(r.u_delta));
        compare_state();
        while (touched.size() > 0) begin
            a = touched.pop_front();
            check_byte($sformatf("mem[%h]", a), mem_i.mem[a], model_mem[a]);
        end
    endtask

    initial begin
        void'($urandom(32'h28968d0d));
        {rst, cen, psh_go, pul_go, psh_all, rti_cc, rti_other, ld_en} = 8'b1100_0000;
        op = 8'h00;
        postdata = 8'h00;
        ld_sel = REG_CC;
        ld_data = 16'h0000;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        model_mem = mem_i.mem;
        foreach (m_reg[i]) m_reg[i] = 16'h0000;
        m_s = `STK_S_RESET;
        m_u = `STK_U_RESET;
        compare_state();
        check_byte("busy", {7'd0, busy}, 8'h00);
        check_byte("we", {7'd0, we}, 8'h00);
        for (int r = 0; r < NROWS; r++) begin
            run_row(rows[r]);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* common/stk_macros.svh */
/* stack engine constants
   flag positions, push/pull opcodes and stack pointer reset values */
`ifndef STK_MACROS_SVH
`define STK_MACROS_SVH

// entire-state flag in CC, picks full or short interrupt frames
`define STK_CC_E 7

// bit 0 of the opcode selects the U stack
`define STK_OP_PSHS 8'h34
`define STK_OP_PSHU 8'h35
`define STK_OP_PULS 8'h36
`define STK_OP_PULU 8'h37

// pointer values after reset
`define STK_S_RESET 16'h8000
`define STK_U_RESET 16'h4000

`endif

/* common/stk_pkg.sv */
/* stack engine package
   postbyte mask view and register index encoding shared by the engine */
package stk_pkg;

    // one postbyte read two ways as a raw mask or as named register bits
    typedef union packed {
        logic [7:0] raw;          // mask cleared bit by bit by the sequencer
        struct packed {
            logic pc;             // bit 7, pushed first
            logic us;             // the other stack pointer
            logic y;
            logic x;
            logic dp;
            logic b;
            logic a;
            logic cc;             // bit 0, pulled first
        } regs;
    } stk_postbyte_u;

    // register indices, same order as the postbyte bits
    typedef enum logic [2:0] {
        REG_CC = 3'd0,
        REG_A  = 3'd1,
        REG_B  = 3'd2,
        REG_DP = 3'd3,
        REG_X  = 3'd4,
        REG_Y  = 3'd5,
        REG_US = 3'd6,
        REG_PC = 3'd7
    } stk_reg_e;

endpackage

/* logic/stk_addr.sv */
/* stack address unit
   keeps S and U and drives the byte bus address and write strobe */
`timescale 1ns/1ps
`include "stk_macros.svh"

module stk_addr (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        busy,
    input  logic        psh_dec,
    input  logic        pul_en,
    input  logic        us_sel,
    input  logic        pull_us_en,
    input  logic [15:0] pull_us,
    output logic [15:0] addr,
    output logic        we,
    output logic [15:0] other_sp,
    output logic [15:0] reg_s,
    output logic [15:0] reg_u
);

    logic [15:0] act_ptr;           // pointer used by this request
    logic [15:0] act_next;          // its value after the current byte
    logic        step;              // a byte moves this cycle

    assign act_ptr  = us_sel ? reg_u : reg_s;
    assign act_next = psh_dec ? act_ptr - 16'd1 : act_ptr + 16'd1;
    assign step     = busy & (psh_dec | pul_en);

    // push writes below the pointer, pull reads at it
    assign addr     = psh_dec ? act_next : act_ptr;
    assign we       = psh_dec;
    assign other_sp = us_sel ? reg_s : reg_u;   // the pointer that can be stacked

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_s <= `STK_S_RESET;
            reg_u <= `STK_U_RESET;
        end else if (cen) begin
            if (step) begin
                if (us_sel) begin
                    reg_u <= act_next;
                end else begin
                    reg_s <= act_next;
                end
            end
            if (pull_us_en) begin               // byte of the other pointer pulled
                if (us_sel) begin
                    reg_s <= pull_us;
                end else begin
                    reg_u <= pull_us;
                end
            end
        end
    end

endmodule

/* logic/stk_regfile.sv */
/* stack register file
   holds the programmer registers, picks the next one from the mask and moves its bytes */
`timescale 1ns/1ps

module stk_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  stk_pkg::stk_postbyte_u psh_sel,
    input  logic                   hihalf,
    input  logic                   pul_en,
    input  logic [7:0]             din,
    input  logic                   ld_en,
    input  stk_pkg::stk_reg_e      ld_sel,
    input  logic [15:0]            ld_data,
    input  logic [15:0]            other_sp,
    output stk_pkg::stk_postbyte_u psh_bit,
    output logic [7:0]             dout,
    output logic [7:0]             cc,
    output logic [15:0]            pull_us,
    output logic                   pull_us_en,
    output logic [7:0]             reg_cc,
    output logic [7:0]             reg_a,
    output logic [7:0]             reg_b,
    output logic [7:0]             reg_dp,
    output logic [15:0]            reg_x,
    output logic [15:0]            reg_y,
    output logic [15:0]            reg_pc
);
    import stk_pkg::*;

    logic        idle;              // no request in flight
    logic        hi_byte;           // this byte is the upper half of a word
    logic [7:0]  lowest;            // lowest set mask bit, pull order
    logic [15:0] word_out;          // word register being pushed

    // highest set bit as a one-hot mask, push order
    function automatic logic [7:0] top_bit(input logic [7:0] m);
        logic [7:0] r;
        r = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) begin
                r = 8'h01 << i;     // later bits override
            end
        end
        return r;
    endfunction

    // replace one half of a word with a pulled byte
    function automatic logic [15:0] put_byte(input logic [15:0] w, input logic hi,
                                             input logic [7:0] b);
        return hi ? {b, w[7:0]} : {w[15:8], b};
    endfunction

    assign idle    = psh_sel.raw == 8'h00;
    assign lowest  = psh_sel.raw & (~psh_sel.raw + 8'd1);
    assign hi_byte = hihalf ^ pul_en;   // push low byte first, pull high byte first
    assign cc      = reg_cc;

    always_comb begin
        psh_bit.raw = pul_en ? lowest : top_bit(psh_sel.raw);
    end

    // byte out for a push
    always_comb begin
        word_out = 16'h0000;
        case (1'b1)
            psh_bit.regs.pc: word_out = reg_pc;
            psh_bit.regs.us: word_out = other_sp;   // stacked copy of the other pointer
            psh_bit.regs.y:  word_out = reg_y;
            psh_bit.regs.x:  word_out = reg_x;
            default:         word_out = 16'h0000;
        endcase
        dout = hi_byte ? word_out[15:8] : word_out[7:0];
        case (1'b1)
            psh_bit.regs.dp: dout = reg_dp;
            psh_bit.regs.b:  dout = reg_b;
            psh_bit.regs.a:  dout = reg_a;
            psh_bit.regs.cc: dout = reg_cc;
            default:         dout = dout;          // word byte chosen above
        endcase
    end

    // pulled US goes straight back to the address unit
    assign pull_us    = put_byte(other_sp, hi_byte, din);
    assign pull_us_en = pul_en & psh_bit.regs.us;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_cc <= 8'h00;
            reg_a  <= 8'h00;
            reg_b  <= 8'h00;
            reg_dp <= 8'h00;
            reg_x  <= 16'h0000;
            reg_y  <= 16'h0000;
            reg_pc <= 16'h0000;
        end else if (cen) begin
            if (idle && ld_en) begin
                case (ld_sel)
                    REG_CC: reg_cc <= ld_data[7:0];
                    REG_A:  reg_a  <= ld_data[7:0];
                    REG_B:  reg_b  <= ld_data[7:0];
                    REG_DP: reg_dp <= ld_data[7:0];
                    REG_X:  reg_x  <= ld_data;
                    REG_Y:  reg_y  <= ld_data;
                    REG_US: ;                       // pointers live in the address unit
                    REG_PC: reg_pc <= ld_data;
                endcase
            end else if (pul_en) begin
                if (psh_bit.regs.cc) reg_cc <= din;
                if (psh_bit.regs.a)  reg_a  <= din;
                if (psh_bit.regs.b)  reg_b  <= din;
                if (psh_bit.regs.dp) reg_dp <= din;
                if (psh_bit.regs.x)  reg_x  <= put_byte(reg_x, hi_byte, din);
                if (psh_bit.regs.y)  reg_y  <= put_byte(reg_y, hi_byte, din);
                if (psh_bit.regs.pc) reg_pc <= put_byte(reg_pc, hi_byte, din);
            end
        end
    end

endmodule

/* src.f */
+incdir+common
common/stk_pkg.sv
stack/stk_sequencer.sv
logic/stk_regfile.sv
logic/stk_addr.sv
stack/stk_top.sv
bench/tb_stk_mem.sv
bench/tb_stk_top.sv

/* stack/stk_sequencer.sv */
/* stack sequencer
   turns a push/pull request into a shrinking mask and a byte phase */
`timescale 1ns/1ps
`include "stk_macros.svh"

module stk_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic [7:0]             op,
    input  logic [7:0]             postdata,
    input  logic [7:0]             cc,
    input  logic                   psh_go,
    input  logic                   pul_go,
    input  logic                   psh_all,
    input  logic                   rti_cc,
    input  logic                   rti_other,
    input  stk_pkg::stk_postbyte_u psh_bit,
    output stk_pkg::stk_postbyte_u psh_sel,
    output logic                   hihalf,
    output logic                   pul_en,
    output logic                   psh_dec,
    output logic                   us_sel,
    output logic                   busy
);
    import stk_pkg::*;

    stk_postbyte_u start;           // mask loaded on a take
    logic          e_flag;
    logic          special;
    logic          take;
    logic          word_bit;        // current register is 16 bits
    logic          dec_en;          // push direction latched at take

    assign e_flag  = cc[`STK_CC_E];
    assign special = psh_all | rti_cc | rti_other;   // interrupt forms always use S

    always_comb begin
        if (rti_cc) begin
            start.raw = 8'h01;                       // CC alone
        end else if (rti_other) begin
            start.raw = e_flag ? 8'hFE : 8'h80;      // rest of frame or PC only
        end else if (psh_all) begin
            start.raw = e_flag ? 8'hFF : 8'h81;      // full frame or PC+CC
        end else begin
            start.raw = postdata;
        end
    end

    assign busy     = psh_sel.raw != 8'h00;
    assign psh_dec  = dec_en & busy;
    assign take     = !busy && (psh_go || pul_go);
    assign word_bit = psh_bit.regs.pc | psh_bit.regs.us | psh_bit.regs.y | psh_bit.regs.x;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psh_sel.raw <= 8'h00;
            hihalf      <= 1'b0;
            pul_en      <= 1'b0;
            dec_en      <= 1'b0;
            us_sel      <= 1'b0;
        end else if (cen) begin
            if (!busy) begin
                pul_en <= 1'b0;                      // drop direction once idle
                dec_en <= 1'b0;
                if (take) begin
                    psh_sel <= start;                // empty mask stays idle
                    hihalf  <= 1'b0;
                    us_sel  <= op[0] && !special;
                    pul_en  <= pul_go && start.raw != 8'h00;
                    dec_en  <= psh_go && !pul_go && start.raw != 8'h00;
                end
            end else if (word_bit && !hihalf) begin
                hihalf <= 1'b1;                      // second byte of a word
            end else begin
                hihalf      <= 1'b0;
                psh_sel.raw <= psh_sel.raw & ~psh_bit.raw;   // register done
            end
        end
    end

endmodule

/* stack/stk_top.sv */
/* stack push/pull engine top
   sequencer, register file and address unit on one memory byte bus */
`timescale 1ns/1ps

module stk_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [7:0]        op,
    input  logic [7:0]        postdata,
    input  logic              psh_go,
    input  logic              pul_go,
    input  logic              psh_all,
    input  logic              rti_cc,
    input  logic              rti_other,
    input  logic              ld_en,
    input  stk_pkg::stk_reg_e ld_sel,
    input  logic [15:0]       ld_data,
    input  logic [7:0]        din,
    output logic [15:0]       addr,
    output logic [7:0]        dout,
    output logic              we,
    output logic              busy,
    output logic [7:0]        reg_cc,
    output logic [7:0]        reg_a,
    output logic [7:0]        reg_b,
    output logic [7:0]        reg_dp,
    output logic [15:0]       reg_x,
    output logic [15:0]       reg_y,
    output logic [15:0]       reg_pc,
    output logic [15:0]       reg_s,
    output logic [15:0]       reg_u
);
    import stk_pkg::*;

    stk_postbyte_u psh_sel;         // remaining registers
    stk_postbyte_u psh_bit;         // register moving now
    logic          hihalf;
    logic          pul_en;
    logic          psh_dec;
    logic          us_sel;
    logic [7:0]    cc;              // E flag source
    logic [15:0]   other_sp;
    logic [15:0]   pull_us;
    logic          pull_us_en;

    stk_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op        (op),
        .postdata  (postdata),
        .cc        (cc),
        .psh_go    (psh_go),
        .pul_go    (pul_go),
        .psh_all   (psh_all),
        .rti_cc    (rti_cc),
        .rti_other (rti_other),
        .psh_bit   (psh_bit),
        .psh_sel   (psh_sel),
        .hihalf    (hihalf),
        .pul_en    (pul_en),
        .psh_dec   (psh_dec),
        .us_sel    (us_sel),
        .busy      (busy)
    );

    stk_regfile u_regs (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .psh_sel    (psh_sel),
        .hihalf     (hihalf),
        .pul_en     (pul_en),
        .din        (din),
        .ld_en      (ld_en),
        .ld_sel     (ld_sel),
        .ld_data    (ld_data),
        .other_sp   (other_sp),
        .psh_bit    (psh_bit),
        .dout       (dout),
        .cc         (cc),
        .pull_us    (pull_us),
        .pull_us_en (pull_us_en),
        .reg_cc     (reg_cc),
        .reg_a      (reg_a),
        .reg_b      (reg_b),
        .reg_dp     (reg_dp),
        .reg_x      (reg_x),
        .reg_y      (reg_y),
        .reg_pc     (reg_pc)
    );

    stk_addr u_addr (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .busy       (busy),
        .psh_dec    (psh_dec),
        .pul_en     (pul_en),
        .us_sel     (us_sel),
        .pull_us_en (pull_us_en),
        .pull_us    (pull_us),
        .addr       (addr),
        .we         (we),
        .other_sp   (other_sp),
        .reg_s      (reg_s),
        .reg_u      (reg_u)
    );

endmodule
